// File: Bender.yml
package:
  name: fetchFrontEnd

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - pcTypes.sv
      - fetchTypes.sv
      - branchTargetBuffer.sv
      - fetchPcUnit.sv
      - fetchSerialCounter.sv
      - fetchControl.sv
      - fetchFrontEnd.sv
  - target: test
    include_dirs:
      - .
    files:
      - fetchFrontEnd_sva.sv
      - fetchFrontEnd_tb.sv

// File: branchTargetBuffer.sv
// =========================================================================
// Branch target buffer
// Direct-mapped, looked up for every slot of the current fetch line and
// written through one update port from the back end
// =========================================================================

`include "fetch_params.svh"

module branchTargetBuffer (
    input  logic                               clock,
    input  logic                               reset,
    input  pcTypes::PcWord                     pc,
    input  logic                               updateValid,
    input  pcTypes::Addr                       updatePc,
    input  pcTypes::Addr                       updateTarget,
    input  logic                               updateTaken,
    output fetchTypes::SlotMask                btbHit,
    output fetchTypes::SlotMask                btbTaken,
    output pcTypes::Addr [`FETCH_WIDTH-1:0]    btbTarget
);

    localparam int Entries = 1 << `BTB_INDEX_WIDTH;

    logic [Entries-1:0]            entryValid;
    logic [Entries-1:0]            entryTaken;
    pcTypes::BtbTag                entryTag    [Entries];
    logic [pcTypes::SlotWidth-1:0] entrySlot   [Entries];
    pcTypes::Addr                  entryTarget [Entries];

    pcTypes::PcWord                updateWord;
    pcTypes::PcWord                lookupWord  [`FETCH_WIDTH];

    always_comb begin
        updateWord.raw = updatePc;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entryValid <= '0;
        end else if (updateValid) begin
            entryValid[updateWord.fields.btbIndex] <= 1'b1;
        end
    end

    // All slots of a line share one index, so the entry also keeps its slot
    always_ff @(posedge clock) begin
        if (updateValid) begin
            entryTag[updateWord.fields.btbIndex]    <= updateWord.fields.tag;
            entrySlot[updateWord.fields.btbIndex]   <= updateWord.fields.slot;
            entryTarget[updateWord.fields.btbIndex] <= updateTarget;
            entryTaken[updateWord.fields.btbIndex]  <= updateTaken;
        end
    end

    // Per-slot lookup on the line address of the fetch PC
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lookupWord[i] = pc;
            lookupWord[i].fields.slot = pcTypes::SlotWidth'(i);
            lookupWord[i].fields.byteOffset = '0;

            btbHit[i] = entryValid[lookupWord[i].fields.btbIndex]
                && entryTag[lookupWord[i].fields.btbIndex] == lookupWord[i].fields.tag
                && entrySlot[lookupWord[i].fields.btbIndex] == lookupWord[i].fields.slot;
            btbTaken[i] = btbHit[i] && entryTaken[lookupWord[i].fields.btbIndex];
            btbTarget[i] = entryTarget[lookupWord[i].fields.btbIndex];
        end
    end

endmodule

// File: fetchControl.sv
// =========================================================================
// Fetch controller
// Runs the four-phase memory handshake, captures the line, holds the group
// for the decoder and drops lines fetched before a redirect
// =========================================================================

module fetchControl (
    input  logic clock,
    input  logic reset,
    input  logic memAck,
    input  logic groupReady,
    input  logic recoveryValid,
    output logic memReq,
    output logic issue,
    output logic lineLoad,
    output logic groupValid,
    output logic advance
);

    fetchTypes::FetchState state;
    fetchTypes::FetchState nextState;
    logic                  discard;
    logic                  nextDiscard;

    always_comb begin
        nextState = state;
        nextDiscard = discard;
        issue = 1'b0;
        lineLoad = 1'b0;
        advance = 1'b0;

        case (state)
            fetchTypes::ISSUE: begin
                // A redirect here moves the PC, so the request waits a cycle
                if (!recoveryValid) begin
                    issue = 1'b1;
                    nextState = fetchTypes::WAIT_ACK;
                end
            end
            fetchTypes::WAIT_ACK: begin
                if (recoveryValid) begin
                    nextDiscard = 1'b1;
                end
                if (memAck) begin
                    lineLoad = !discard && !recoveryValid;
                    nextState = fetchTypes::WAIT_RELEASE;
                end
            end
            fetchTypes::WAIT_RELEASE: begin
                if (recoveryValid) begin
                    nextDiscard = 1'b1;
                end
                // Handshake closes once ack is back low
                if (!memAck) begin
                    nextDiscard = 1'b0;
                    if (discard || recoveryValid) begin
                        nextState = fetchTypes::ISSUE;
                    end else begin
                        nextState = fetchTypes::HOLD;
                    end
                end
            end
            fetchTypes::HOLD: begin
                if (recoveryValid) begin
                    nextState = fetchTypes::ISSUE;
                end else if (groupReady) begin
                    advance = 1'b1;
                    nextState = fetchTypes::ISSUE;
                end
            end
            default: begin
                nextState = fetchTypes::ISSUE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= fetchTypes::ISSUE;
            discard <= 1'b0;
        end else begin
            state   <= nextState;
            discard <= nextDiscard;
        end
    end

    assign memReq = (state == fetchTypes::WAIT_ACK);

    // Not offered to the decoder in the cycle the redirect arrives
    assign groupValid = (state == fetchTypes::HOLD) && !recoveryValid;

endmodule

// File: fetchFrontEnd.f
+incdir+.
pcTypes.sv
fetchTypes.sv
branchTargetBuffer.sv
fetchPcUnit.sv
fetchSerialCounter.sv
fetchControl.sv
fetchFrontEnd.sv
fetchFrontEnd_sva.sv
fetchFrontEnd_tb.sv

// File: fetchFrontEnd.sv
// =========================================================================
// Instruction fetch front end
// Top level joining the fetch controller, PC unit, BTB and serial counter
// =========================================================================

`include "fetch_params.svh"

module fetchFrontEnd (
    input  logic                clock,
    input  logic                reset,
    input  logic                memAck,
    input  fetchTypes::InsnLine memLine,
    input  logic                groupReady,
    input  logic                recoveryValid,
    input  pcTypes::Addr        recoveryPc,
    input  logic                updateValid,
    input  pcTypes::Addr        updatePc,
    input  pcTypes::Addr        updateTarget,
    input  logic                updateTaken,
    output logic                memReq,
    output pcTypes::Addr        memAddr,
    output logic                groupValid,
    output pcTypes::Addr        groupPc,
    output fetchTypes::SlotMask groupMask,
    output fetchTypes::InsnLine groupInsns,
    output fetchTypes::Serial   groupSerial
);

    logic                            issue;
    logic                            lineLoad;
    logic                            advance;
    pcTypes::PcWord                  pc;
    fetchTypes::SlotMask             btbHit;
    fetchTypes::SlotMask             btbTaken;
    pcTypes::Addr [`FETCH_WIDTH-1:0] btbTarget;

    fetchControl control (
        .clock         (clock),
        .reset         (reset),
        .memAck        (memAck),
        .groupReady    (groupReady),
        .recoveryValid (recoveryValid),
        .memReq        (memReq),
        .issue         (issue),
        .lineLoad      (lineLoad),
        .groupValid    (groupValid),
        .advance       (advance)
    );

    fetchPcUnit pcUnit (
        .clock         (clock),
        .reset         (reset),
        .issue         (issue),
        .lineLoad      (lineLoad),
        .advance       (advance),
        .recoveryValid (recoveryValid),
        .recoveryPc    (recoveryPc),
        .memLine       (memLine),
        .btbHit        (btbHit),
        .btbTaken      (btbTaken),
        .btbTarget     (btbTarget),
        .pc            (pc),
        .memAddr       (memAddr),
        .groupPc       (groupPc),
        .groupMask     (groupMask),
        .groupInsns    (groupInsns)
    );

    branchTargetBuffer btb (
        .clock        (clock),
        .reset        (reset),
        .pc           (pc),
        .updateValid  (updateValid),
        .updatePc     (updatePc),
        .updateTarget (updateTarget),
        .updateTaken  (updateTaken),
        .btbHit       (btbHit),
        .btbTaken     (btbTaken),
        .btbTarget    (btbTarget)
    );

    fetchSerialCounter serialCounter (
        .clock       (clock),
        .reset       (reset),
        .advance     (advance),
        .groupMask   (groupMask),
        .groupSerial (groupSerial)
    );

endmodule

// File: fetchFrontEnd_sva.sv
// =========================================================================
// Fetch front end assertions
// Memory handshake rules and the hold of the group offered to the decoder
// =========================================================================

module fetchFrontEndAssertions (
    input logic                clock,
    input logic                reset,
    input logic                memReq,
    input logic                memAck,
    input pcTypes::Addr        memAddr,
    input logic                groupValid,
    input logic                groupReady,
    input logic                recoveryValid,
    input pcTypes::Addr        groupPc,
    input fetchTypes::SlotMask groupMask,
    input fetchTypes::InsnLine groupInsns,
    input fetchTypes::Serial   groupSerial
);

    // Failed assertions so far
    int failCount = 0;

    // Request address fixed from request until ack has fallen
    addrStable: assert property (@(posedge clock) disable iff (reset)
        (memReq || memAck) && $past(memReq || memAck) |-> $stable(memAddr))
        else begin
            $error("memAddr changed during an open memory handshake");
            failCount++;
        end

    noEarlyRequest: assert property (@(posedge clock) disable iff (reset)
        $rose(memReq) |-> !memAck)
        else begin
            $error("memReq rose while memAck was still high");
            failCount++;
        end

    groupHeld: assert property (@(posedge clock) disable iff (reset)
        groupValid && !groupReady |=> recoveryValid
            || (groupValid && $stable(groupPc) && $stable(groupMask)
                && $stable(groupInsns) && $stable(groupSerial)))
        else begin
            $error("Held group changed before the decoder accepted it");
            failCount++;
        end

endmodule

bind fetchFrontEnd fetchFrontEndAssertions handshakeChecks (
    .clock         (clock),
    .reset         (reset),
    .memReq        (memReq),
    .memAck        (memAck),
    .memAddr       (memAddr),
    .groupValid    (groupValid),
    .groupReady    (groupReady),
    .recoveryValid (recoveryValid),
    .groupPc       (groupPc),
    .groupMask     (groupMask),
    .groupInsns    (groupInsns),
    .groupSerial   (groupSerial)
);

// File: fetchFrontEnd_tb.sv
// =========================================================================
// Fetch front end testbench
// Four-phase memory model, decoder back-pressure, redirects and BTB
// updates, checked against a reference model of the group sequence
// =========================================================================

`include "fetch_params.svh"

module fetchFrontEnd_tb;

    localparam int ClockPeriod = 20;
    localparam int LineBytes = `FETCH_WIDTH * `INSN_BYTES;
    localparam int IndexLow = $clog2(LineBytes);
    localparam int BtbEntries = 1 << `BTB_INDEX_WIDTH;
    // Accepted groups of all tests plus lines dropped by redirects
    localparam int TotalGroups = 48;
    // Issue, ack delay, release, hold and decoder stalls
    localparam int HandshakeCycles = 16;
    localparam int TimeoutTime = TotalGroups * HandshakeCycles * ClockPeriod * 2;

    logic                clock;
    logic                reset;
    logic                memReq;
    logic                memAck;
    pcTypes::Addr        memAddr;
    fetchTypes::InsnLine memLine;
    logic                groupReady;
    logic                recoveryValid;
    pcTypes::Addr        recoveryPc;
    logic                updateValid;
    pcTypes::Addr        updatePc;
    pcTypes::Addr        updateTarget;
    logic                updateTaken;
    logic                groupValid;
    pcTypes::Addr        groupPc;
    fetchTypes::SlotMask groupMask;
    fetchTypes::InsnLine groupInsns;
    fetchTypes::Serial   groupSerial;

    logic [31:0] ackLfsr;
    logic [31:0] readyLfsr;
    // 0 always ready, 1 random stalls, 2 stalled
    int          readyMode;
    int          acceptedCount;
    int          errorCount;
    int          testErrors;
    int          testCount;
    int          testStart;
    int          slotTotal;

    // Model BTB keeps the full branch address of each entry
    logic              modelValid  [BtbEntries];
    pcTypes::Addr      modelBranch [BtbEntries];
    pcTypes::Addr      modelTarget [BtbEntries];
    logic              modelTaken  [BtbEntries];
    pcTypes::Addr      modelPc;
    fetchTypes::Serial modelSerial;

    fetchFrontEnd dut (
        .clock         (clock),
        .reset         (reset),
        .memAck        (memAck),
        .memLine       (memLine),
        .groupReady    (groupReady),
        .recoveryValid (recoveryValid),
        .recoveryPc    (recoveryPc),
        .updateValid   (updateValid),
        .updatePc      (updatePc),
        .updateTarget  (updateTarget),
        .updateTaken   (updateTaken),
        .memReq        (memReq),
        .memAddr       (memAddr),
        .groupValid    (groupValid),
        .groupPc       (groupPc),
        .groupMask     (groupMask),
        .groupInsns    (groupInsns),
        .groupSerial   (groupSerial)
    );

    initial begin
        clock = 1'b0;
        forever #(ClockPeriod / 2) clock = ~clock;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] randomBits(inout logic [31:0] state, input int count);
        logic [31:0] bits;
        logic        feedback;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
            state = {state[30:0], feedback};
            bits = {bits[30:0], feedback};
        end
        return bits;
    endfunction

    // Memory contents, every word mixes all address bits
    function automatic fetchTypes::InsnLine lineAt(input pcTypes::Addr lineAddr);
        fetchTypes::InsnLine line;
        pcTypes::Addr        a;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            a = lineAddr + pcTypes::Addr'(i * `INSN_BYTES);
            line[i] = {a[15:0], a[31:16]} ^ (a << 3) ^ 32'h5a3c_9e17;
        end
        return line;
    endfunction

    function automatic int countSlots(input fetchTypes::SlotMask mask);
        int count;
        count = 0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            count += int'(mask[i]);
        end
        return count;
    endfunction

    // Reference: valid slots from the start slot up to the first predicted
    // taken branch, and the PC of the following group
    function automatic void predictGroup(input pcTypes::Addr startPc,
            output fetchTypes::SlotMask mask, output pcTypes::Addr next);
        pcTypes::Addr                  base;
        pcTypes::Addr                  slotAddr;
        logic [`BTB_INDEX_WIDTH-1:0]   index;
        logic                          taken;
        base = startPc & ~pcTypes::Addr'(LineBytes - 1);
        next = base + pcTypes::Addr'(LineBytes);
        mask = '0;
        taken = 1'b0;
        for (int i = int'(startPc[IndexLow-1:2]); i < `FETCH_WIDTH && !taken; i++) begin
            slotAddr = base + pcTypes::Addr'(i * `INSN_BYTES);
            index = slotAddr[IndexLow +: `BTB_INDEX_WIDTH];
            mask[i] = 1'b1;
            if (modelValid[index] && modelBranch[index] == slotAddr && modelTaken[index]) begin
                taken = 1'b1;
                next = modelTarget[index];
            end
        end
    endfunction

    task automatic checkAddr(input string name, input pcTypes::Addr actual,
            input pcTypes::Addr expected);
        if (actual !== expected) begin
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic checkMask(input string name, input fetchTypes::SlotMask actual,
            input fetchTypes::SlotMask expected);
        if (actual !== expected) begin
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic checkLine(input string name, input fetchTypes::InsnLine actual,
            input fetchTypes::InsnLine expected);
        if (actual !== expected) begin
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic checkSerial(input string name, input fetchTypes::Serial actual,
            input fetchTypes::Serial expected);
        if (actual !== expected) begin
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
            errorCount++;
            testErrors++;
        end
    endtask

    // Four-phase responder with a random ack delay of 0 to 3 cycles
    initial begin : memoryResponder
        int delay;
        memAck = 1'b0;
        memLine = '0;
        ackLfsr = 32'hc739da41;
        forever begin
            @(posedge clock);
            if (memReq === 1'b1 && !reset) begin
                delay = int'(randomBits(ackLfsr, 2));
                repeat (delay) @(posedge clock);
                memAck <= 1'b1;
                memLine <= lineAt(memAddr);
                @(posedge clock);
                while (memReq === 1'b1) @(posedge clock);
                memAck <= 1'b0;
            end
        end
    end

    always @(posedge clock) begin
        if (readyMode == 1) begin
            groupReady <= randomBits(readyLfsr, 1) != 0;
        end else begin
            groupReady <= (readyMode == 0);
        end
    end

    // Sampled at the falling edge, so the values hold for the next rising edge
    always @(negedge clock) begin : compareGroups
        fetchTypes::SlotMask         expMask;
        pcTypes::Addr                expNext;
        logic [`BTB_INDEX_WIDTH-1:0] index;
        if (!reset) begin
            if (updateValid) begin
                index = updatePc[IndexLow +: `BTB_INDEX_WIDTH];
                modelValid[index] = 1'b1;
                modelBranch[index] = updatePc;
                modelTarget[index] = updateTarget;
                modelTaken[index] = updateTaken;
            end
            if (recoveryValid) begin
                modelPc = recoveryPc;
            end else if (groupValid && groupReady) begin
                predictGroup(modelPc, expMask, expNext);
                checkAddr("groupPc", groupPc, modelPc);
                checkMask("groupMask", groupMask, expMask);
                checkLine("groupInsns", groupInsns,
                    lineAt(modelPc & ~pcTypes::Addr'(LineBytes - 1)));
                checkSerial("groupSerial", groupSerial, modelSerial);
                modelSerial += fetchTypes::Serial'(countSlots(expMask));
                slotTotal += countSlots(expMask);
                modelPc = expNext;
                acceptedCount++;
            end
        end
    end

    // Recovery pulse, optionally with a BTB update in the same cycle
    task automatic redirect(input pcTypes::Addr target, input logic doUpdate,
            input pcTypes::Addr branch, input pcTypes::Addr branchTarget, input logic taken);
        @(posedge clock);
        recoveryValid <= 1'b1;
        recoveryPc <= target;
        updateValid <= doUpdate;
        updatePc <= branch;
        updateTarget <= branchTarget;
        updateTaken <= taken;
        @(posedge clock);
        recoveryValid <= 1'b0;
        updateValid <= 1'b0;
    endtask

    task automatic waitGroups(input int count);
        int target;
        target = acceptedCount + count;
        while (acceptedCount < target) @(posedge clock);
    endtask

    task automatic startTest();
        testStart = acceptedCount;
        testErrors = 0;
        testCount++;
    endtask

    task automatic reportTest(input string name);
        $display("Test %0d %s: %0d groups, %0d errors", testCount, name,
            acceptedCount - testStart, testErrors);
    endtask

    initial begin
        reset = 1'b1;
        groupReady = 1'b0;
        recoveryValid = 1'b0;
        recoveryPc = '0;
        updateValid = 1'b0;
        updatePc = '0;
        updateTarget = '0;
        updateTaken = 1'b0;
        readyLfsr = 32'hc739da41;
        readyMode = 0;
        acceptedCount = 0;
        errorCount = 0;
        testCount = 0;
        slotTotal = 0;
        modelPc = `RESET_PC;
        modelSerial = fetchTypes::Serial'(1);
        for (int i = 0; i < BtbEntries; i++) begin
            modelValid[i] = 1'b0;
        end
        repeat (10) @(posedge clock);
        reset <= 1'b0;

        startTest();
        waitGroups(4);
        redirect(32'h0000_2008, 1'b0, '0, '0, 1'b0);
        waitGroups(3);
        reportTest("sequential fetch");

        startTest();
        redirect(32'h0000_3000, 1'b1, 32'h0000_3004, 32'h0000_4008, 1'b1);
        waitGroups(3);
        reportTest("taken branch");

        // Not-taken entry, then an entry whose tag belongs to another line
        startTest();
        redirect(32'h0000_5000, 1'b1, 32'h0000_5008, 32'h0000_6000, 1'b0);
        waitGroups(2);
        redirect(32'h0000_6000, 1'b1, 32'h0000_7004, 32'h0000_1000, 1'b1);
        waitGroups(2);
        reportTest("no taken prediction");

        startTest();
        @(negedge clock);
        while (memReq !== 1'b1) @(negedge clock);
        redirect(32'h0000_8004, 1'b0, '0, '0, 1'b0);
        waitGroups(2);
        @(negedge clock);
        readyMode = 2;
        @(negedge clock);
        while (!(groupValid && !groupReady)) @(negedge clock);
        redirect(32'h0000_9000, 1'b0, '0, '0, 1'b0);
        @(negedge clock);
        readyMode = 0;
        waitGroups(2);
        reportTest("recovery redirect");

        startTest();
        @(negedge clock);
        readyMode = 1;
        waitGroups(16);
        @(negedge clock);
        readyMode = 0;
        reportTest("decoder back-pressure");

        // Serial must equal one plus every valid slot accepted so far
        startTest();
        redirect(32'h0000_a00c, 1'b0, '0, '0, 1'b0);
        waitGroups(3);
        @(negedge clock);
        readyMode = 2;
        repeat (3) @(negedge clock);
        checkSerial("groupSerial", groupSerial, fetchTypes::Serial'(1 + slotTotal));
        reportTest("serial numbering");

        errorCount += dut.handshakeChecks.failCount;
        $display("%0d tests, %0d groups accepted, %0d errors", testCount, acceptedCount,
            errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(TimeoutTime);
        $display("Timeout: the fetch front end stopped delivering groups");
        $display("Something failed");
        $finish;
    end

endmodule

// File: fetchPcUnit.sv
// =========================================================================
// Fetch PC unit
// Keeps the fetch PC and the line request address, captures the fetched
// line and forms the slot mask and the predicted next PC of the group
// =========================================================================

`include "fetch_params.svh"

module fetchPcUnit (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               issue,
    input  logic                               lineLoad,
    input  logic                               advance,
    input  logic                               recoveryValid,
    input  pcTypes::Addr                       recoveryPc,
    input  fetchTypes::InsnLine                memLine,
    input  fetchTypes::SlotMask                btbHit,
    input  fetchTypes::SlotMask                btbTaken,
    input  pcTypes::Addr [`FETCH_WIDTH-1:0]    btbTarget,
    output pcTypes::PcWord                     pc,
    output pcTypes::Addr                       memAddr,
    output pcTypes::Addr                       groupPc,
    output fetchTypes::SlotMask                groupMask,
    output fetchTypes::InsnLine                groupInsns
);

    localparam int LineBytes = `FETCH_WIDTH * `INSN_BYTES;

    pcTypes::PcWord      lineBase;
    pcTypes::Addr        nextLinePc;
    pcTypes::Addr        predNextPc;
    pcTypes::Addr        nextPc;
    fetchTypes::SlotMask slotMask;
    logic                takenSeen;

    // Mask and next PC prediction for the line at the current PC
    always_comb begin
        lineBase = pc;
        lineBase.fields.slot = '0;
        lineBase.fields.byteOffset = '0;
        nextLinePc = lineBase.raw + pcTypes::Addr'(LineBytes);

        predNextPc = nextLinePc;
        slotMask = '0;
        takenSeen = 1'b0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            // Slots before the start slot and after a taken branch stay invalid
            if (pcTypes::SlotWidth'(i) >= pc.fields.slot && !takenSeen) begin
                slotMask[i] = 1'b1;
                if (btbHit[i] && btbTaken[i]) begin
                    takenSeen = 1'b1;
                    predNextPc = btbTarget[i];
                end
            end
        end
    end

    // Recovery wins over a group advance
    always_ff @(posedge clock) begin
        if (reset) begin
            pc.raw <= `RESET_PC;
        end else if (recoveryValid) begin
            pc.raw <= recoveryPc;
        end else if (advance) begin
            pc.raw <= nextPc;
        end
    end

    // Request address is line aligned and held for the whole handshake
    always_ff @(posedge clock) begin
        if (issue) begin
            memAddr <= lineBase.raw;
        end
    end

    // Group contents are frozen at line capture, so a BTB write
    // during the hold cannot change them
    always_ff @(posedge clock) begin
        if (lineLoad) begin
            groupInsns <= memLine;
            groupMask  <= slotMask;
            nextPc     <= predNextPc;
        end
    end

    assign groupPc = pc.raw;

endmodule

// File: fetchSerialCounter.sv
// =========================================================================
// Fetch serial counter
// Numbers fetched instructions, starting at 1 and stepping by the number
// of valid slots in each accepted group
// =========================================================================

`include "fetch_params.svh"

module fetchSerialCounter (
    input  logic                clock,
    input  logic                reset,
    input  logic                advance,
    input  fetchTypes::SlotMask groupMask,
    output fetchTypes::Serial   groupSerial
);

    localparam int CountWidth = $clog2(`FETCH_WIDTH + 1);

    logic [CountWidth-1:0] validCount;

    // Population count of the group mask
    always_comb begin
        validCount = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            validCount = validCount + CountWidth'(groupMask[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            groupSerial <= fetchTypes::Serial'(1);
        end else if (advance) begin
            groupSerial <= groupSerial + fetchTypes::Serial'(validCount);
        end
    end

endmodule

// File: fetchTypes.sv
// =========================================================================
// Fetch types
// Instruction words, slot masks, serial numbers and controller states
// =========================================================================

`include "fetch_params.svh"

package fetchTypes;

    typedef logic [31:0] Insn;

    // Slot 0 sits in the low word
    typedef Insn [`FETCH_WIDTH-1:0] InsnLine;

    typedef logic [`FETCH_WIDTH-1:0] SlotMask;

    typedef logic [`SERIAL_WIDTH-1:0] Serial;

    typedef enum logic [1:0] {
        ISSUE,
        WAIT_ACK,
        WAIT_RELEASE,
        HOLD
    } FetchState;

endpackage

// File: fetch_params.svh
// =========================================================================
// Fetch front end parameters
// Widths, sizes and the reset PC shared by the packages and the RTL
// =========================================================================

`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Slots per fetch group, equal to instructions per cache line
`define FETCH_WIDTH 4
`define ADDR_WIDTH 32
`define INSN_BYTES 4

// 16 BTB entries
`define BTB_INDEX_WIDTH 4
`define SERIAL_WIDTH 16

`define RESET_PC 32'h0000_1000

`endif

// File: pcTypes.sv
// =========================================================================
// PC types
// Byte address, PC field layout and the PC word seen as raw or as fields
// =========================================================================

`include "fetch_params.svh"

package pcTypes;

    localparam int SlotWidth = $clog2(`FETCH_WIDTH);
    localparam int ByteOffsetWidth = $clog2(`INSN_BYTES);
    localparam int TagWidth = `ADDR_WIDTH - `BTB_INDEX_WIDTH - SlotWidth - ByteOffsetWidth;

    typedef logic [`ADDR_WIDTH-1:0] Addr;

    typedef logic [TagWidth-1:0] BtbTag;

    // From the top: BTB tag, BTB index, slot in line, byte in instruction
    typedef struct packed {
        BtbTag                       tag;
        logic [`BTB_INDEX_WIDTH-1:0] btbIndex;
        logic [SlotWidth-1:0]        slot;
        logic [ByteOffsetWidth-1:0]  byteOffset;
    } PcFields;

    // Same word read either as an address or as its fields
    typedef union packed {
        Addr     raw;
        PcFields fields;
    } PcWord;

endpackage
